/* files.f */
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
cpu.sv
tb_cpu.sv

/* Bender.yml */
package:
  name: rv32i_core

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - rv_pipe_pkg.sv
      - rv_decode.sv
      - rv_execute.sv
      - rv_result.sv
      - cpu.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu.sv

/* tb_cpu.sv */
// testbench for the rv32i core
// random instruction streams checked against a register file model

`include "rv_macros.svh"

module tb_cpu;

	import rv_isa_pkg::*;

	// one expected retire, phase names the stream it came from
	typedef struct packed {
		logic [2:0]             phase;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0]       data;
		logic                   wreg;
		logic                   illegal;
	} retire_rec_t;

	localparam int N_FILL  = 31;
	localparam int N_INDEP = 60;
	localparam int N_DEP   = 60;
	localparam int N_STALL = 60;
	localparam int N_X0    = 40;
	localparam int N_SHIFT = 40;
	localparam int N_TOTAL = N_FILL + N_INDEP + N_DEP + N_STALL + N_X0 + N_SHIFT;
	localparam int CYCLE_LIMIT = 2 * N_TOTAL + 50;

	logic                   clk_in = 1'b0;
	logic                   reset_i;
	logic                   rdy_i;
	logic                   inst_valid_i;
	logic [31:0]            inst_i;
	logic [`REG_ADDR_W-1:0] dbg_sel_i;
	logic [`XLEN-1:0]       dbgreg_o;
	logic                   retire_valid_o;
	logic [`REG_ADDR_W-1:0] retire_rd_o;
	logic [`XLEN-1:0]       retire_data_o;
	logic                   retire_wreg_o;
	logic                   retire_illegal_o;
	logic [`XLEN-1:0]       retired_count_o;

	// model state
	logic [`XLEN-1:0]       model_regs [`REG_COUNT];
	retire_rec_t            expect_q [$];
	logic [2:0]             phase;
	logic [4:0]             last_rd1;
	logic [4:0]             last_rd2;
	int                     stall_pct;
	int                     sent;
	int                     cycles;
	int                     mismatch_count;
	int                     other_count;

	cpu DUT (.*);

	always #4 clk_in = ~clk_in;

	function automatic string phase_name(input logic [2:0] p);
		case (p)
			3'd0:    return "lui_fill";
			3'd1:    return "independent";
			3'd2:    return "dependent";
			3'd3:    return "rdy_stall";
			3'd4:    return "x0_illegal";
			default: return "shift";
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			mismatch_count++;
		end
	endtask

	// encoders
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, OPC_LUI};
	endfunction

	// legal op or op-imm with random funct3
	function automatic logic [31:0] rand_alu(input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [4:0] rd);
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm;
		f3  = $urandom % 8;
		alt = $urandom % 2;
		imm = $urandom;
		if ($urandom % 2) begin
			// alternate form exists only for sub and sra
			if (!(f3 == 3'b000 || f3 == 3'b101))
				alt = 1'b0;
			return r_type(alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd);
		end
		if (f3 == 3'b001)
			imm[11:5] = 7'b0;
		else if (f3 == 3'b101)
			imm[11:5] = alt ? 7'b0100000 : 7'b0;
		return i_type(imm, rs1, f3, rd);
	endfunction

	// source register not written by the last two instructions
	function automatic logic [4:0] pick_free_reg();
		logic [4:0] r;
		r = $urandom;
		while (r == last_rd1 || r == last_rd2)
			r = $urandom;
		return r;
	endfunction

	// rv32i meaning of one word against the model registers
	function automatic retire_rec_t model_inst(input logic [31:0] inst);
		retire_rec_t rec;
		logic [31:0] a;
		logic [31:0] b;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic        alt;
		logic        is_alu;
		f3          = inst[14:12];
		f7          = inst[31:25];
		a           = model_regs[inst[19:15]];
		b           = {{20{inst[31]}}, inst[31:20]};
		alt         = 1'b0;
		is_alu      = 1'b0;
		rec.phase   = phase;
		rec.rd      = inst[11:7];
		rec.data    = '0;
		rec.illegal = 1'b0;
		case (inst[6:0])
			OPC_LUI: rec.data = {inst[31:12], 12'b0};
			OPC_OP: begin
				is_alu      = 1'b1;
				b           = model_regs[inst[24:20]];
				alt         = f7[5];
				rec.illegal = !(f7 == 7'b0 ||
					(f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)));
			end
			OPC_OP_IMM: begin
				is_alu = 1'b1;
				// only the shift immediates constrain the top bits
				alt    = (f3 == 3'b101) && f7[5];
				if (f3 == 3'b001)
					rec.illegal = (f7 != 7'b0);
				else if (f3 == 3'b101)
					rec.illegal = !(f7 == 7'b0 || f7 == 7'b0100000);
			end
			default: rec.illegal = 1'b1;
		endcase
		if (is_alu) begin
			case (f3)
				3'b000: rec.data = alt ? a - b : a + b;
				3'b001: rec.data = a << b[4:0];
				3'b010: rec.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				3'b011: rec.data = (a < b) ? 32'd1 : 32'd0;
				3'b100: rec.data = a ^ b;
				3'b101: begin
					if (alt)
						rec.data = $signed(a) >>> b[4:0];
					else
						rec.data = a >> b[4:0];
				end
				3'b110: rec.data = a | b;
				default: rec.data = a & b;
			endcase
		end
		rec.wreg = !rec.illegal && rec.rd != '0;
		return rec;
	endfunction

	// offer one instruction, possibly behind a rdy low stretch
	task automatic send(input logic [31:0] inst);
		retire_rec_t rec;
		@(negedge clk_in);
		// junk words offered while rdy is low must be ignored
		while (stall_pct > 0 && ($urandom % 100) < stall_pct) begin
			rdy_i        = 1'b0;
			inst_valid_i = $urandom % 2;
			inst_i       = $urandom;
			@(negedge clk_in);
		end
		rdy_i        = 1'b1;
		inst_valid_i = 1'b1;
		inst_i       = inst;
		rec          = model_inst(inst);
		if (rec.wreg)
			model_regs[rec.rd] = rec.data;
		expect_q.push_back(rec);
		sent++;
		last_rd2 = last_rd1;
		last_rd1 = inst[11:7];
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk_in);
			rdy_i        = 1'b1;
			inst_valid_i = 1'b0;
		end
	endtask

	// retire checker, outputs stable before the edge
	always @(posedge clk_in) begin
		retire_rec_t rec;
		if (!reset_i && retire_valid_o === 1'b1) begin
			if (expect_q.size() == 0) begin
				$display("retire of x%0d with no instruction outstanding", retire_rd_o);
				other_count++;
			end else begin
				rec = expect_q.pop_front();
				compare({phase_name(rec.phase), " rd"}, rec.rd, retire_rd_o);
				compare({phase_name(rec.phase), " wreg"}, rec.wreg, retire_wreg_o);
				compare({phase_name(rec.phase), " illegal"}, rec.illegal, retire_illegal_o);
				// illegal words carry no defined data
				if (!rec.illegal)
					compare({phase_name(rec.phase), " data"}, rec.data, retire_data_o);
			end
		end
	end

	always @(posedge clk_in) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		logic [4:0] rs1;
		logic [4:0] rd;
		logic [2:0] f3;
		logic [6:0] f7;
		void'($urandom(32'hde18));
		reset_i        = 1'b1;
		rdy_i          = 1'b1;
		inst_valid_i   = 1'b0;
		inst_i         = '0;
		dbg_sel_i      = '0;
		last_rd1       = '0;
		last_rd2       = '0;
		stall_pct      = 0;
		sent           = 0;
		cycles         = 0;
		mismatch_count = 0;
		other_count    = 0;
		for (int i = 0; i < `REG_COUNT; i++)
			model_regs[i] = '0;
		repeat (2) @(negedge clk_in);
		reset_i = 1'b0;

		// load every register with an upper immediate
		phase = 3'd0;
		for (int i = 1; i <= N_FILL; i++)
			send(u_type(20'($urandom), 5'(i)));
		phase = 3'd1;
		for (int i = 0; i < N_INDEP; i++)
			send(rand_alu(pick_free_reg(), pick_free_reg(), 5'(1 + $urandom % 31)));
		// sources taken from the last two destinations, bypass paths
		phase = 3'd2;
		for (int i = 0; i < N_DEP; i++)
			send(rand_alu(($urandom % 2) ? last_rd1 : last_rd2,
				($urandom % 2) ? last_rd1 : last_rd2, 5'(1 + $urandom % 31)));
		phase     = 3'd3;
		stall_pct = 30;
		for (int i = 0; i < N_STALL; i++)
			send(rand_alu(($urandom % 2) ? last_rd1 : 5'($urandom),
				last_rd2, 5'(1 + $urandom % 31)));
		stall_pct = 0;
		// x0 targets, random words, bad funct7 forms
		phase = 3'd4;
		for (int i = 0; i < N_X0; i++) begin
			rs1 = $urandom;
			case ($urandom % 4)
				0:       send(rand_alu(rs1, 5'($urandom), 5'd0));
				1:       send($urandom);
				2:       send(r_type(7'b0000001, 5'($urandom), rs1, 3'($urandom), 5'($urandom)));
				default: send(i_type({7'b0100001, 5'($urandom)}, rs1, 3'b101, 5'($urandom)));
			endcase
		end
		// negative value then a shift of it, forwarded
		phase = 3'd5;
		for (int i = 0; i < N_SHIFT / 2; i++) begin
			rd = 1 + $urandom % 31;
			send(u_type({1'b1, 19'($urandom)}, rd));
			f3 = ($urandom % 2) ? 3'b101 : 3'b001;
			f7 = (f3 == 3'b101 && $urandom % 3 != 0) ? 7'b0100000 : 7'b0;
			if ($urandom % 2)
				send(r_type(f7, 5'($urandom), rd, f3, 5'(1 + $urandom % 31)));
			else
				send(i_type({f7, 5'($urandom)}, rd, f3, 5'(1 + $urandom % 31)));
		end

		idle(1);
		while (expect_q.size() != 0)
			@(negedge clk_in);
		// extra cycles expose duplicated retires
		idle(4);
		compare("retired_count", sent, retired_count_o);
		for (int i = 0; i < `REG_COUNT; i++) begin
			@(negedge clk_in);
			dbg_sel_i = i;
			@(posedge clk_in);
			compare($sformatf("regfile x%0d", i), model_regs[i], dbgreg_o);
		end

		$display("errors: %0d value mismatches, %0d other failures",
			mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* cpu.sv */
// rv32i core top level
// decode, execute and result stages with their bypass paths

`include "rv_macros.svh"

module cpu (
	input  logic                   clk_in,
	input  logic                   reset_i,
	// pause the whole core while low
	input  logic                   rdy_i,
	input  logic                   inst_valid_i,
	input  logic [31:0]            inst_i,
	// debug register read
	input  logic [`REG_ADDR_W-1:0] dbg_sel_i,
	output logic [`XLEN-1:0]       dbgreg_o,
	// retire report
	output logic                   retire_valid_o,
	output logic [`REG_ADDR_W-1:0] retire_rd_o,
	output logic [`XLEN-1:0]       retire_data_o,
	output logic                   retire_wreg_o,
	output logic                   retire_illegal_o,
	output logic [`XLEN-1:0]       retired_count_o
);

	import rv_pipe_pkg::*;

	// stage chain
	dec_to_ex_t             dec_to_ex;
	ex_to_res_t             ex_to_res;

	// bypass sources
	fwd_t                   ex_fwd;
	fwd_t                   res_fwd;

	// decode to register file
	logic [`REG_ADDR_W-1:0] rs1_addr;
	logic [`REG_ADDR_W-1:0] rs2_addr;
	logic [`XLEN-1:0]       rs1_data;
	logic [`XLEN-1:0]       rs2_data;

	rv_decode u_decode (
		.clk_in       (clk_in),
		.reset_i      (reset_i),
		.rdy_i        (rdy_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.rs1_addr_o   (rs1_addr),
		.rs2_addr_o   (rs2_addr),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.ex_fwd_i     (ex_fwd),
		.res_fwd_i    (res_fwd),
		.dec_o        (dec_to_ex)
	);

	rv_execute u_execute (
		.clk_in   (clk_in),
		.reset_i  (reset_i),
		.rdy_i    (rdy_i),
		.dec_i    (dec_to_ex),
		.ex_fwd_o (ex_fwd),
		.res_o    (ex_to_res)
	);

	rv_result u_result (
		.clk_in           (clk_in),
		.reset_i          (reset_i),
		.rdy_i            (rdy_i),
		.res_i            (ex_to_res),
		.rs1_addr_i       (rs1_addr),
		.rs2_addr_i       (rs2_addr),
		.rs1_data_o       (rs1_data),
		.rs2_data_o       (rs2_data),
		.dbg_sel_i        (dbg_sel_i),
		.dbgreg_o         (dbgreg_o),
		.res_fwd_o        (res_fwd),
		.retire_valid_o   (retire_valid_o),
		.retire_rd_o      (retire_rd_o),
		.retire_data_o    (retire_data_o),
		.retire_wreg_o    (retire_wreg_o),
		.retire_illegal_o (retire_illegal_o),
		.retired_count_o  (retired_count_o)
	);

endmodule

/* rv_result.sv */
// result stage
// register file, retire report and retire counter

`include "rv_macros.svh"

module rv_result (
	input  logic                    clk_in,
	input  logic                    reset_i,
	input  logic                    rdy_i,
	input  rv_pipe_pkg::ex_to_res_t res_i,
	input  logic [`REG_ADDR_W-1:0]  rs1_addr_i,
	input  logic [`REG_ADDR_W-1:0]  rs2_addr_i,
	output logic [`XLEN-1:0]        rs1_data_o,
	output logic [`XLEN-1:0]        rs2_data_o,
	input  logic [`REG_ADDR_W-1:0]  dbg_sel_i,
	output logic [`XLEN-1:0]        dbgreg_o,
	output rv_pipe_pkg::fwd_t       res_fwd_o,
	output logic                    retire_valid_o,
	output logic [`REG_ADDR_W-1:0]  retire_rd_o,
	output logic [`XLEN-1:0]        retire_data_o,
	output logic                    retire_wreg_o,
	output logic                    retire_illegal_o,
	output logic [`XLEN-1:0]        retired_count_o
);

	logic [`XLEN-1:0] regs [`REG_COUNT];
	logic             retire;

	// one retire per rdy-high edge
	assign retire = res_i.valid && rdy_i;

	// write port, x0 left untouched
	always_ff @(posedge clk_in) begin
		if (reset_i) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (retire && res_i.wreg && res_i.rd != '0) begin
			regs[res_i.rd] <= res_i.data;
		end
	end

	// read ports, combinational
	assign rs1_data_o = regs[rs1_addr_i];
	assign rs2_data_o = regs[rs2_addr_i];
	assign dbgreg_o   = regs[dbg_sel_i];

	// value about to be written, covers the write edge
	assign res_fwd_o.wreg = res_i.valid && res_i.wreg;
	assign res_fwd_o.rd   = res_i.rd;
	assign res_fwd_o.data = res_i.data;

	// retire report
	assign retire_valid_o   = retire;
	assign retire_rd_o      = res_i.rd;
	assign retire_data_o    = res_i.data;
	assign retire_wreg_o    = res_i.wreg;
	assign retire_illegal_o = res_i.illegal;

	always_ff @(posedge clk_in) begin
		if (reset_i)
			retired_count_o <= '0;
		else if (retire)
			retired_count_o <= retired_count_o + 1'b1;
	end

	// x0 reads zero on every port
	assert property (@(posedge clk_in) disable iff (reset_i)
		((rs1_addr_i == '0) |-> (rs1_data_o == '0)) and
		((rs2_addr_i == '0) |-> (rs2_data_o == '0)) and
		((dbg_sel_i == '0) |-> (dbgreg_o == '0)));

endmodule

/* rv_execute.sv */
// execute stage
// rv32i alu, bypass source and execute pipeline register

`include "rv_macros.svh"

module rv_execute (
	input  logic                    clk_in,
	input  logic                    reset_i,
	input  logic                    rdy_i,
	input  rv_pipe_pkg::dec_to_ex_t dec_i,
	output rv_pipe_pkg::fwd_t       ex_fwd_o,
	output rv_pipe_pkg::ex_to_res_t res_o
);

	import rv_isa_pkg::*;

	word_t      alu_res;
	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	// shifts take only the low five bits of b
	assign shamt = dec_i.b[4:0];
	assign lt_s  = $signed(dec_i.a) < $signed(dec_i.b);
	assign lt_u  = dec_i.a < dec_i.b;

	always_comb begin
		case (dec_i.alu_op)
			ALU_ADD:    alu_res = dec_i.a + dec_i.b;
			ALU_SUB:    alu_res = dec_i.a - dec_i.b;
			ALU_SLL:    alu_res = dec_i.a << shamt;
			ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, lt_s};
			ALU_SLTU:   alu_res = {{(`XLEN-1){1'b0}}, lt_u};
			ALU_XOR:    alu_res = dec_i.a ^ dec_i.b;
			ALU_SRL:    alu_res = dec_i.a >> shamt;
			// arithmetic shift keeps the sign
			ALU_SRA:    alu_res = $signed(dec_i.a) >>> shamt;
			ALU_OR:     alu_res = dec_i.a | dec_i.b;
			ALU_AND:    alu_res = dec_i.a & dec_i.b;
			ALU_PASS_B: alu_res = dec_i.b;
			default:    alu_res = '0;
		endcase
	end

	// newest result, bypassed to decode in the same cycle
	assign ex_fwd_o.wreg = dec_i.wreg;
	assign ex_fwd_o.rd   = dec_i.rd;
	assign ex_fwd_o.data = alu_res;

	// execute pipeline register
	always_ff @(posedge clk_in) begin
		if (reset_i) begin
			res_o.valid   <= 1'b0;
			res_o.illegal <= 1'b0;
			res_o.wreg    <= 1'b0;
		end else if (rdy_i) begin
			res_o.valid   <= dec_i.valid;
			res_o.illegal <= dec_i.illegal;
			res_o.wreg    <= dec_i.wreg;
			res_o.rd      <= dec_i.rd;
			res_o.data    <= alu_res;
		end
	end

	// decode only raises wreg for a live instruction
	assert property (@(posedge clk_in) disable iff (reset_i)
		ex_fwd_o.wreg |-> dec_i.valid);

endmodule

/* rv_decode.sv */
// decode stage
// instruction capture, opcode decode, immediates and operand bypass

`include "rv_macros.svh"

module rv_decode (
	input  logic                    clk_in,
	input  logic                    reset_i,
	input  logic                    rdy_i,
	input  logic                    inst_valid_i,
	input  logic [31:0]             inst_i,
	output logic [`REG_ADDR_W-1:0]  rs1_addr_o,
	output logic [`REG_ADDR_W-1:0]  rs2_addr_o,
	input  logic [`XLEN-1:0]        rs1_data_i,
	input  logic [`XLEN-1:0]        rs2_data_i,
	input  rv_pipe_pkg::fwd_t       ex_fwd_i,
	input  rv_pipe_pkg::fwd_t       res_fwd_i,
	output rv_pipe_pkg::dec_to_ex_t dec_o
);

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	// captured instruction
	logic                   inst_valid_q;
	logic [31:0]            inst_q;

	// instruction fields
	logic [6:0]             funct7;
	logic [2:0]             funct3;
	logic [`REG_ADDR_W-1:0] rd;
	logic                   alt;
	word_t                  imm_i;
	word_t                  imm_u;
	word_t                  rs1_val;
	word_t                  rs2_val;

	// decode results
	logic                   illegal;
	alu_op_e                alu_op;
	word_t                  op_a;
	word_t                  op_b;

	// newest writer wins and x0 stays zero
	function automatic word_t pick_operand(
		input logic [`REG_ADDR_W-1:0] addr,
		input word_t                  rf_data,
		input fwd_t                   ex_fwd,
		input fwd_t                   res_fwd
	);
		if (addr == '0)
			return '0;
		if (ex_fwd.wreg && ex_fwd.rd == addr)
			return ex_fwd.data;
		if (res_fwd.wreg && res_fwd.rd == addr)
			return res_fwd.data;
		return rf_data;
	endfunction

	// funct3 to alu op with alt picking sub / sra
	function automatic alu_op_e base_op(input logic [2:0] f3, input logic use_alt);
		case (f3)
			3'b000:  return use_alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return use_alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// stage register held while rdy is low
	always_ff @(posedge clk_in) begin
		if (reset_i) begin
			inst_valid_q <= 1'b0;
		end else if (rdy_i) begin
			inst_valid_q <= inst_valid_i;
			// word only matters together with valid
			if (inst_valid_i)
				inst_q <= inst_i;
		end
	end

	assign funct7     = inst_q[31:25];
	assign funct3     = inst_q[14:12];
	assign rd         = inst_q[11:7];
	assign alt        = (funct7 == F7_ALT);
	assign rs1_addr_o = inst_q[19:15];
	assign rs2_addr_o = inst_q[24:20];

	// sign extended i-type and u-type in upper bits
	assign imm_i = {{(`XLEN-12){inst_q[31]}}, inst_q[31:20]};
	assign imm_u = {inst_q[31:12], 12'b0};

	assign rs1_val = pick_operand(rs1_addr_o, rs1_data_i, ex_fwd_i, res_fwd_i);
	assign rs2_val = pick_operand(rs2_addr_o, rs2_data_i, ex_fwd_i, res_fwd_i);

	always_comb begin
		illegal = 1'b0;
		alu_op  = ALU_ADD;
		op_a    = rs1_val;
		op_b    = rs2_val;
		case (opcode_e'(inst_q[6:0]))
			OPC_OP: begin
				alu_op = base_op(funct3, alt);
				// alternate funct7 only for add/sub and srl/sra
				if (alt)
					illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
				else if (funct7 != F7_BASE)
					illegal = 1'b1;
			end
			OPC_OP_IMM: begin
				op_b = imm_i;
				// addi has no alternate form so top imm bits are data
				alu_op = base_op(funct3, (funct3 == 3'b101) && alt);
				// shamt forms keep funct7 in the immediate
				if (funct3 == 3'b001)
					illegal = (funct7 != F7_BASE);
				else if (funct3 == 3'b101)
					illegal = !(alt || funct7 == F7_BASE);
			end
			OPC_LUI: begin
				alu_op = ALU_PASS_B;
				op_a   = '0;
				op_b   = imm_u;
			end
			default: illegal = 1'b1;
		endcase
	end

	// decode pipeline register
	always_ff @(posedge clk_in) begin
		if (reset_i) begin
			dec_o.valid   <= 1'b0;
			dec_o.illegal <= 1'b0;
			dec_o.wreg    <= 1'b0;
		end else if (rdy_i) begin
			dec_o.valid   <= inst_valid_q;
			dec_o.illegal <= inst_valid_q && illegal;
			// x0 destination retires without a write
			dec_o.wreg    <= inst_valid_q && !illegal && (rd != '0);
			dec_o.rd      <= rd;
			dec_o.alu_op  <= alu_op;
			dec_o.a       <= op_a;
			dec_o.b       <= op_b;
		end
	end

	// unknown major opcode leaves decode as illegal with no register write
	assert property (@(posedge clk_in) disable iff (reset_i)
		rdy_i && inst_valid_q && !(inst_q[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LUI})
		|=> dec_o.illegal && !dec_o.wreg);

endmodule

/* rv_pipe_pkg.sv */
// stage to stage records of the three stage pipeline
// decode to execute, execute to result, forwarding source

`include "rv_macros.svh"

package rv_pipe_pkg;

	// decode register, read by the alu
	typedef struct packed {
		logic                   valid;
		logic                   illegal;
		// set only for legal instructions with rd != x0
		logic                   wreg;
		logic [`REG_ADDR_W-1:0] rd;
		rv_isa_pkg::alu_op_e    alu_op;
		logic [`XLEN-1:0]       a;
		// immediate already merged in where the instruction has one
		logic [`XLEN-1:0]       b;
	} dec_to_ex_t;

	// execute register, feeds retire and register write
	typedef struct packed {
		logic                   valid;
		logic                   illegal;
		logic                   wreg;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0]       data;
	} ex_to_res_t;

	// bypass source seen by decode
	typedef struct packed {
		logic                   wreg;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0]       data;
	} fwd_t;

endpackage

/* rv_isa_pkg.sv */
// rv32i encodings used by the core
// major opcodes, funct7 patterns and alu operation codes

`include "rv_macros.svh"

package rv_isa_pkg;

	// one architectural data word
	typedef logic [`XLEN-1:0] word_t;

	// major opcodes the core understands, inst[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111
	} opcode_e;

	// funct7 patterns
	// alternate form selects sub and sra / srai
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// alu operations
	// low three bits follow funct3, top bit marks the alternate form
	typedef enum logic [3:0] {
		ALU_ADD    = 4'b0000,
		ALU_SLL    = 4'b0001,
		ALU_SLT    = 4'b0010,
		ALU_SLTU   = 4'b0011,
		ALU_XOR    = 4'b0100,
		ALU_SRL    = 4'b0101,
		ALU_OR     = 4'b0110,
		ALU_AND    = 4'b0111,
		ALU_SUB    = 4'b1000,
		ALU_SRA    = 4'b1101,
		// lui, result is operand b
		ALU_PASS_B = 4'b1111
	} alu_op_e;

endpackage

/* rv_macros.svh */
// width and size defines shared by the packages and the core
// data width, register count, register address width

`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// integer register and datapath width
`define XLEN 32

// architectural register file size
`define REG_COUNT 32

// register index width, log2 of REG_COUNT
`define REG_ADDR_W 5

`endif
